// File: bench/nf_clk_gen.sv
// clock and reset source for the core testbench
// 10 ns clock, rst_n held low for the first 3 rising edges
`timescale 1ns/1ps

module nf_clk_gen
(
    output  logic   clk,        // 100 MHz clock
    output  logic   rst_n       // sync reset, active low
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;              // 10 ns period
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;                      // released on the third edge
    end

endmodule : nf_clk_gen

// File: bench/nf_cpu_props.sv
// port level assertions for the single-cycle core
// attached to nf_cpu_core by a bind in the testbench
`timescale 1ns/1ps

module nf_cpu_props
(
    input   logic                               clk,        // core clock
    input   logic                               rst_n,      // sync reset, active low
    input   logic                               instr_vld,  // instruction strobe
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    pc,         // program counter
    input   logic                               wb_we       // writeback enable
);

    pc_aligned : assert property (@(posedge clk) disable iff (!rst_n) pc[1 : 0] == 2'b00)
        else $error("pc is not word aligned");

    no_wb_idle : assert property (@(posedge clk) disable iff (!rst_n) !instr_vld |-> !wb_we)
        else $error("wb_we high without instr_vld");

    // pc only moves on an edge that saw a valid instruction
    pc_hold : assert property (@(posedge clk) disable iff (!rst_n) !instr_vld |=> $stable(pc))
        else $error("pc moved after a cycle without instr_vld");

    no_wb_reset : assert property (@(posedge clk) !rst_n |-> !wb_we)
        else $error("wb_we high during reset");

endmodule : nf_cpu_props

// File: bench/nf_cpu_tb.sv
// testbench of the single-cycle rv32i core
// random program image, strobed instruction driver and an iss reference model
// outputs are checked on the falling edge, inputs change on the rising edge
`timescale 1ns/1ps

module nf_cpu_tb;

    localparam logic [31 : 0]   RESET_PC = 32'h0000_0100;  // non-zero to catch reset bugs
    localparam int              N_INSTR  = 400;            // valid instructions to run
    localparam int              TIMEOUT  = 2000;           // cycles per wait loop

    logic           clk;
    logic           rst_n;
    logic           instr_vld;
    logic   [31 : 0] instr;
    logic   [31 : 0] pc;
    logic           wb_we;
    logic   [4 : 0] wb_addr;
    logic   [31 : 0] wb_data;

    logic   [31 : 0] prog [0 : 63];     // program image, indexed by pc bits 7..2
    logic   [31 : 0] m_regs [0 : 31];   // iss register file
    logic   [31 : 0] m_pc;              // iss program counter
    int             errors;
    int             n_exec;             // valid instructions retired

    nf_clk_gen clk_gen_0
    (
        .clk    ( clk   ),
        .rst_n  ( rst_n )
    );

    nf_cpu_core #( .RESET_PC ( RESET_PC ) ) nf_cpu_core_i
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .instr_vld  ( instr_vld ),
        .instr      ( instr     ),
        .pc         ( pc        ),
        .wb_we      ( wb_we     ),
        .wb_addr    ( wb_addr   ),
        .wb_data    ( wb_data   )
    );

    bind nf_cpu_core nf_cpu_props cpu_props_0
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .instr_vld  ( instr_vld ),
        .pc         ( pc        ),
        .wb_we      ( wb_we     )
    );

    task automatic report_mismatch(input string name, input logic [31 : 0] got,
                                   input logic [31 : 0] exp);
        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    // rv32i integer semantics by funct3, alt selects sub / sra
    function automatic logic [31 : 0] ref_alu(input logic [2 : 0] f3, input logic alt,
                                              input logic [31 : 0] x, input logic [31 : 0] y,
                                              input logic [4 : 0] sh);
        logic   [31 : 0] r;
        case (f3)
            3'b000  : r = alt ? x - y : x + y;
            3'b001  : r = x << sh;
            3'b010  : r = {31'b0, (x[31] != y[31]) ? x[31] : (x < y)};   // signed compare
            3'b011  : r = {31'b0, x < y};
            3'b100  : r = x ^ y;
            3'b101  : r = alt ? ((x >> sh) | (x[31] ? ~(32'hffff_ffff >> sh) : 32'h0))
                              : x >> sh;                               // sign fill for sra
            3'b110  : r = x | y;
            default : r = x & y;
        endcase
        return r;
    endfunction

    // one legal instruction from the kept set, registers limited to x0..x7
    function automatic logic [31 : 0] random_instr();
        logic   [31 : 0] r;
        logic   [31 : 0] r2;                // immediate bits
        logic   [4 : 0]  rd;
        logic   [4 : 0]  rs1;
        logic   [4 : 0]  rs2;
        logic   [2 : 0]  f3;
        logic   [6 : 0]  f7;
        logic   [12 : 0] off;
        logic   [31 : 0] ins;
        r   = $urandom;
        r2  = $urandom;
        rd  = {2'b00, r[2 : 0]};            // small set, many hazards and x0 hits
        rs1 = {2'b00, r[5 : 3]};
        rs2 = {2'b00, r[8 : 6]};
        f3  = r[11 : 9];
        f7  = 7'b0;
        case (r[14 : 12])
            3'd0, 3'd1 :
            begin
                if (((f3 == 3'b000) || (f3 == 3'b101)) && r[15])
                    f7 = 7'b0100000;        // sub / sra
                ins = {f7, rs2, rs1, f3, rd, nf_cpu_pkg::OP};
            end
            3'd2, 3'd3 :
            begin
                if (f3 == 3'b001)
                    ins = {7'b0, r2[4 : 0], rs1, f3, rd, nf_cpu_pkg::OP_IMM};
                else if (f3 == 3'b101)      // srli or srai
                    ins = {1'b0, r[15], 5'b0, r2[4 : 0], rs1, f3, rd, nf_cpu_pkg::OP_IMM};
                else
                    ins = {r2[31 : 20], rs1, f3, rd, nf_cpu_pkg::OP_IMM};
            end
            3'd4 : ins = {r2[31 : 12], rd, nf_cpu_pkg::LUI};
            3'd5 : ins = {r2[31 : 12], rd, nf_cpu_pkg::AUIPC};
            default :
            begin
                off = {8'b0, {1'b0, r2[1 : 0]} + 3'd1, 2'b00};   // forward 4..16
                ins = {off[12], off[10 : 5], rs2, rs1, {2'b00, r2[2]}, off[4 : 1], off[11],
                       nf_cpu_pkg::BRANCH};
            end
        endcase
        return ins;
    endfunction

    // compare one cycle against the iss, then retire into the model
    task automatic check_step(input logic vld, input logic [31 : 0] ins);
        logic   [6 : 0]  opc;
        logic   [4 : 0]  rd;
        logic   [2 : 0]  f3;
        logic   [6 : 0]  f7;
        logic   [31 : 0] a;
        logic   [31 : 0] b;
        logic   [31 : 0] imm_i;
        logic   [31 : 0] imm_u;
        logic   [31 : 0] imm_b;
        logic            exp_we;
        logic   [31 : 0] exp_res;
        logic   [31 : 0] next_pc;
        opc     = ins[6 : 0];
        rd      = ins[11 : 7];
        f3      = ins[14 : 12];
        f7      = ins[31 : 25];
        a       = m_regs[ins[19 : 15]];
        b       = m_regs[ins[24 : 20]];
        imm_i   = {{20{ins[31]}}, ins[31 : 20]};
        imm_u   = {ins[31 : 12], 12'b0};
        imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30 : 25], ins[11 : 8], 1'b0};
        exp_we  = 1'b0;
        exp_res = '0;
        next_pc = m_pc + 32'd4;
        if (pc !== m_pc)
            report_mismatch("pc", pc, m_pc);
        if (!vld)
        begin
            if (wb_we !== 1'b0)
                report_mismatch("wb_we", {31'b0, wb_we}, 32'd0);
            return;                         // idle cycle, model unchanged
        end
        case (opc)
            nf_cpu_pkg::OP :
            begin
                exp_we  = 1'b1;
                exp_res = ref_alu(f3, f7 == 7'b0100000, a, b, b[4 : 0]);
            end
            nf_cpu_pkg::OP_IMM :
            begin
                exp_we  = 1'b1;
                exp_res = ref_alu(f3, (f3 == 3'b101) && (f7 == 7'b0100000), a, imm_i,
                                  ins[24 : 20]);
            end
            nf_cpu_pkg::LUI :
            begin
                exp_we  = 1'b1;
                exp_res = imm_u;
            end
            nf_cpu_pkg::AUIPC :
            begin
                exp_we  = 1'b1;
                exp_res = m_pc + imm_u;
            end
            nf_cpu_pkg::BRANCH :
                if (((f3 == 3'b000) && (a == b)) || ((f3 == 3'b001) && (a != b)))
                    next_pc = m_pc + imm_b;     // taken
            default : ;
        endcase
        if (wb_we !== exp_we)
            report_mismatch("wb_we", {31'b0, wb_we}, {31'b0, exp_we});
        if (exp_we)
        begin
            if (wb_addr !== rd)
                report_mismatch("wb_addr", {27'b0, wb_addr}, {27'b0, rd});
            if (wb_data !== exp_res)
                report_mismatch("wb_data", wb_data, exp_res);
            if (rd != 5'd0)
                m_regs[rd] = exp_res;       // x0 stays zero
        end
        m_pc = next_pc;
        n_exec++;
    endtask

    initial
    begin
        int             waited;
        int             cycles;
        logic           vld;
        logic   [31 : 0] cur;
        logic   [31 : 0] r;
        void'($urandom(32'h3c5b9d2b));
        instr_vld = 1'b0;
        instr     = '0;
        errors    = 0;
        n_exec    = 0;
        waited    = 0;
        cycles    = 0;
        m_pc      = RESET_PC;
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        for (int i = 0; i < 64; i++)
            prog[i] = random_instr();
        while ((rst_n !== 1'b1) && (waited < TIMEOUT))
        begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1)
        begin
            $display("reset was never released within %0d cycles", TIMEOUT);
            errors++;
        end
        else
        begin
            if (pc !== RESET_PC)
                report_mismatch("pc", pc, RESET_PC);
            if (wb_we !== 1'b0)
                report_mismatch("wb_we", {31'b0, wb_we}, 32'd0);
            while ((n_exec < N_INSTR) && (cycles < TIMEOUT))
            begin
                @(posedge clk);
                r   = $urandom;
                vld = (r % 100) < 80;       // about 80 percent valid
                cur = prog[m_pc[7 : 2]];    // image wraps every 64 words
                instr_vld <= vld;
                instr     <= cur;
                @(negedge clk);
                check_step(vld, cur);
                cycles++;
            end
            if (n_exec < N_INSTR)
            begin
                $display("timeout, only %0d of %0d instructions ran in %0d cycles",
                         n_exec, N_INSTR, TIMEOUT);
                errors++;
            end
            else
            begin
                @(posedge clk);
                instr_vld <= 1'b0;          // idle cycle exposes the last pc update
                @(negedge clk);
                check_step(1'b0, '0);
            end
        end
        $display("executed %0d instructions, %0d errors", n_exec, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule : nf_cpu_tb

// File: hdl/nf_alu.sv
// combinational alu, arithmetic, logic, compare and shifts
// shifts operate on srca by the separate shift amount
`timescale 1ns/1ps

module nf_alu
(
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    srca,       // source a
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    srcb,       // source b
    input   logic   [4 : 0]                     shift,      // shift amount
    input   nf_cpu_pkg::alu_code_e              alu_code,   // operation
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    result      // result
);

    always_comb
    begin
        result = '0;
        case (alu_code)
            nf_cpu_pkg::ALU_ADD  : result = srca + srcb;
            nf_cpu_pkg::ALU_SUB  : result = srca - srcb;
            nf_cpu_pkg::ALU_SLL  : result = srca << shift;
            nf_cpu_pkg::ALU_SRL  : result = srca >> shift;
            nf_cpu_pkg::ALU_SRA  : result = $signed(srca) >>> shift;   // keeps sign bit
            nf_cpu_pkg::ALU_SLT  : result = { {(nf_cpu_pkg::XLEN-1){1'b0}},
                                              $signed(srca) < $signed(srcb) };
            nf_cpu_pkg::ALU_SLTU : result = { {(nf_cpu_pkg::XLEN-1){1'b0}}, srca < srcb };
            nf_cpu_pkg::ALU_XOR  : result = srca ^ srcb;
            nf_cpu_pkg::ALU_OR   : result = srca | srcb;
            nf_cpu_pkg::ALU_AND  : result = srca & srcb;
            default              : result = '0;
        endcase
    end

endmodule : nf_alu

// File: hdl/nf_control_unit.sv
// instruction decoder of the single-cycle core
// produces exu controls, register addresses, immediate type and branch type
`timescale 1ns/1ps

module nf_control_unit
(
    input   logic   [31 : 0]            instr,          // instruction word
    input   logic                       instr_vld,      // instruction strobe
    nf_exu_ctrl_if.ctrl                 exu,            // exu controls
    output  logic   [4  : 0]            ra1,            // read address 1
    output  logic   [4  : 0]            ra2,            // read address 2
    output  logic   [4  : 0]            wa,             // write address
    output  logic                       we,             // write enable
    output  nf_cpu_pkg::imm_src_e       imm_src,        // immediate format
    output  nf_cpu_pkg::branch_type_e   branch_type,    // branch condition
    output  logic   [4  : 0]            shamt           // immediate shift amount
);

    nf_cpu_pkg::opcode_e    opcode;                 // major opcode
    logic   [2 : 0]         funct3;
    logic   [6 : 0]         funct7;
    logic                   wr_op;                  // opcode writes rd

    // funct3 plus alternate bit to alu code
    function automatic nf_cpu_pkg::alu_code_e f3_to_alu(input logic [2 : 0] f3, input logic alt);
        nf_cpu_pkg::alu_code_e code;
        code = nf_cpu_pkg::ALU_ADD;
        case (f3)
            nf_cpu_pkg::F3_ADD_SUB : code = alt ? nf_cpu_pkg::ALU_SUB : nf_cpu_pkg::ALU_ADD;
            nf_cpu_pkg::F3_SLL     : code = nf_cpu_pkg::ALU_SLL;
            nf_cpu_pkg::F3_SLT     : code = nf_cpu_pkg::ALU_SLT;
            nf_cpu_pkg::F3_SLTU    : code = nf_cpu_pkg::ALU_SLTU;
            nf_cpu_pkg::F3_XOR     : code = nf_cpu_pkg::ALU_XOR;
            nf_cpu_pkg::F3_SRL_SRA : code = alt ? nf_cpu_pkg::ALU_SRA : nf_cpu_pkg::ALU_SRL;
            nf_cpu_pkg::F3_OR      : code = nf_cpu_pkg::ALU_OR;
            nf_cpu_pkg::F3_AND     : code = nf_cpu_pkg::ALU_AND;
            default                : ;
        endcase
        return code;
    endfunction

    assign opcode = nf_cpu_pkg::opcode_e'(instr[6 : 0]);
    assign funct3 = instr[14 : 12];
    assign funct7 = instr[31 : 25];
    assign ra1    = instr[19 : 15];                 // rs1
    assign ra2    = instr[24 : 20];                 // rs2
    assign wa     = instr[11 : 7];                  // rd
    assign shamt  = instr[24 : 20];                 // same field as rs2
    assign we     = instr_vld & wr_op;              // no write without strobe

    always_comb
    begin
        exu.srca_sel  = nf_cpu_pkg::SRCA_RD1;
        exu.srcb_sel  = nf_cpu_pkg::SRCB_RD2;
        exu.shift_sel = nf_cpu_pkg::SRCS_RD2;
        exu.alu_code  = nf_cpu_pkg::ALU_ADD;
        imm_src       = nf_cpu_pkg::IMM_I;
        branch_type   = nf_cpu_pkg::BR_NONE;
        wr_op         = 1'b0;
        case (opcode)
            nf_cpu_pkg::OP :
            begin
                wr_op        = 1'b1;
                exu.alu_code = f3_to_alu(funct3, funct7 == nf_cpu_pkg::F7_SUB_SRA);
            end
            nf_cpu_pkg::OP_IMM :
            begin
                wr_op         = 1'b1;
                exu.srcb_sel  = nf_cpu_pkg::SRCB_IMM;
                exu.shift_sel = nf_cpu_pkg::SRCS_SHAMT;
                // bit 30 only means srai, otherwise it is immediate data
                exu.alu_code  = f3_to_alu(funct3, (funct3 == nf_cpu_pkg::F3_SRL_SRA) &&
                                                  (funct7 == nf_cpu_pkg::F7_SUB_SRA));
            end
            nf_cpu_pkg::LUI :
            begin
                wr_op         = 1'b1;
                imm_src       = nf_cpu_pkg::IMM_U;
                exu.srca_sel  = nf_cpu_pkg::SRCA_IMM;  // u field in srca
                exu.shift_sel = nf_cpu_pkg::SRCS_12;   // shifted up by 12
                exu.alu_code  = nf_cpu_pkg::ALU_SLL;
            end
            nf_cpu_pkg::AUIPC :
            begin
                wr_op         = 1'b1;
                imm_src       = nf_cpu_pkg::IMM_U;
                exu.srca_sel  = nf_cpu_pkg::SRCA_PC;
                exu.srcb_sel  = nf_cpu_pkg::SRCB_12;   // pc + (imm << 12)
            end
            nf_cpu_pkg::BRANCH :
            begin
                imm_src = nf_cpu_pkg::IMM_B;
                if (funct3 == nf_cpu_pkg::F3_BEQ)
                    branch_type = nf_cpu_pkg::BR_EQ;
                else if (funct3 == nf_cpu_pkg::F3_BNE)
                    branch_type = nf_cpu_pkg::BR_NE;
            end
            default : ;                             // unknown, no write, no branch
        endcase
    end

endmodule : nf_control_unit

// File: hdl/nf_cpu_core.sv
// top level of the single-cycle rv32i integer core
// instruction comes in on instr with instr_vld, writeback leaves on wb_*
`timescale 1ns/1ps

module nf_cpu_core
#(
    parameter logic [nf_cpu_pkg::XLEN-1 : 0] RESET_PC = '0     // pc after reset
)(
    input   logic                               clk,        // clock
    input   logic                               rst_n,      // sync reset, active low
    input   logic                               instr_vld,  // instruction strobe
    input   logic   [31 : 0]                    instr,      // instruction word
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    pc,         // program counter
    output  logic                               wb_we,      // writeback enable
    output  logic   [4 : 0]                     wb_addr,    // writeback register
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    wb_data     // writeback data
);

    logic   [4 : 0]                     ra1;
    logic   [4 : 0]                     ra2;
    logic   [4 : 0]                     shamt;
    logic   [nf_cpu_pkg::XLEN-1 : 0]    rd1;
    logic   [nf_cpu_pkg::XLEN-1 : 0]    rd2;
    logic   [nf_cpu_pkg::XLEN-1 : 0]    ext_data;  // extended immediate
    nf_cpu_pkg::imm_src_e               imm_src;
    nf_cpu_pkg::branch_type_e           branch_type;

    nf_exu_ctrl_if exu_ctrl ();                     // decoder to exu

    nf_control_unit control_unit_0
    (
        .instr          ( instr         ),
        .instr_vld      ( instr_vld     ),
        .exu            ( exu_ctrl      ),
        .ra1            ( ra1           ),
        .ra2            ( ra2           ),
        .wa             ( wb_addr       ),
        .we             ( wb_we         ),
        .imm_src        ( imm_src       ),
        .branch_type    ( branch_type   ),
        .shamt          ( shamt         )
    );

    nf_reg_file reg_file_0
    (
        .clk    ( clk       ),
        .rst_n  ( rst_n     ),
        .ra1    ( ra1       ),
        .ra2    ( ra2       ),
        .rd1    ( rd1       ),
        .rd2    ( rd2       ),
        .wa     ( wb_addr   ),
        .wd     ( wb_data   ),          // exu result written back
        .we     ( wb_we     )
    );

    nf_sign_ex sign_ex_0
    (
        .instr      ( instr     ),
        .imm_src    ( imm_src   ),
        .ext_data   ( ext_data  )
    );

    nf_i_exu i_exu_0
    (
        .rd1        ( rd1       ),
        .rd2        ( rd2       ),
        .ext_data   ( ext_data  ),
        .pc_v       ( pc        ),
        .shamt      ( shamt     ),
        .ctrl       ( exu_ctrl  ),
        .result     ( wb_data   )
    );

    nf_pc_unit #( .RESET_PC ( RESET_PC ) ) pc_unit_0
    (
        .clk            ( clk           ),
        .rst_n          ( rst_n         ),
        .instr_vld      ( instr_vld     ),
        .branch_type    ( branch_type   ),
        .rd1            ( rd1           ),
        .rd2            ( rd2           ),
        .ext_data       ( ext_data      ),
        .pc             ( pc            )
    );

endmodule : nf_cpu_core

// File: hdl/nf_cpu_pkg.sv
// shared widths, opcode and control encodings for the single-cycle rv32i core
// referenced by scoped names from the rtl and the testbench
package nf_cpu_pkg;

    localparam int XLEN = 32;                   // data and address width

    // major opcodes kept by this core
    typedef enum logic [6 : 0]
    {
        OP     = 7'b0110011,                    // r-type alu
        OP_IMM = 7'b0010011,                    // i-type alu
        LUI    = 7'b0110111,                    // load upper immediate
        AUIPC  = 7'b0010111,                    // add upper immediate to pc
        BRANCH = 7'b1100011                     // beq / bne
    } opcode_e;

    // alu operation codes
    typedef enum logic [3 : 0]
    {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SRL  = 4'd3,
        ALU_SRA  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_code_e;

    typedef enum logic [1 : 0] { SRCA_RD1, SRCA_IMM, SRCA_PC } srca_sel_e;
    typedef enum logic [1 : 0] { SRCB_RD2, SRCB_IMM, SRCB_12 } srcb_sel_e;   // 12: imm << 12
    typedef enum logic [1 : 0] { SRCS_RD2, SRCS_SHAMT, SRCS_12 } shift_sel_e;
    typedef enum logic [1 : 0] { IMM_I, IMM_U, IMM_B } imm_src_e;
    typedef enum logic [1 : 0] { BR_NONE, BR_EQ, BR_NE } branch_type_e;

    // funct3 values
    localparam logic [2 : 0] F3_ADD_SUB = 3'b000;
    localparam logic [2 : 0] F3_SLL     = 3'b001;
    localparam logic [2 : 0] F3_SLT     = 3'b010;
    localparam logic [2 : 0] F3_SLTU    = 3'b011;
    localparam logic [2 : 0] F3_XOR     = 3'b100;
    localparam logic [2 : 0] F3_SRL_SRA = 3'b101;
    localparam logic [2 : 0] F3_OR      = 3'b110;
    localparam logic [2 : 0] F3_AND     = 3'b111;
    localparam logic [2 : 0] F3_BEQ     = 3'b000;
    localparam logic [2 : 0] F3_BNE     = 3'b001;

    // funct7 marking sub / sra / srai
    localparam logic [6 : 0] F7_SUB_SRA = 7'b0100000;

endpackage : nf_cpu_pkg

// File: hdl/nf_exu_ctrl_if.sv
// execution unit controls, driven by the decoder and read by the exu
// ctrl modport on the decoder side, exu modport on the datapath side
`timescale 1ns/1ps

interface nf_exu_ctrl_if;

    nf_cpu_pkg::srca_sel_e  srca_sel;           // alu source a select
    nf_cpu_pkg::srcb_sel_e  srcb_sel;           // alu source b select
    nf_cpu_pkg::shift_sel_e shift_sel;          // shift amount select
    nf_cpu_pkg::alu_code_e  alu_code;           // alu operation

    modport ctrl
    (
        output  srca_sel, srcb_sel, shift_sel, alu_code
    );

    modport exu
    (
        input   srca_sel, srcb_sel, shift_sel, alu_code
    );

endinterface : nf_exu_ctrl_if

// File: hdl/nf_i_exu.sv
// execution unit, picks alu operands and shift amount, holds the alu
// purely combinational, result goes to writeback
`timescale 1ns/1ps

module nf_i_exu
(
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    rd1,        // reg file port 1
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    rd2,        // reg file port 2
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    ext_data,   // extended immediate
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    pc_v,       // current pc
    input   logic   [4 : 0]                     shamt,      // immediate shift amount
    nf_exu_ctrl_if.exu                          ctrl,       // decoder controls
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    result      // alu result
);

    logic   [nf_cpu_pkg::XLEN-1 : 0]    srca;       // alu source a
    logic   [nf_cpu_pkg::XLEN-1 : 0]    srcb;       // alu source b
    logic   [4 : 0]                     shift;      // alu shift amount

    always_comb
    begin
        srca = rd1;
        case (ctrl.srca_sel)
            nf_cpu_pkg::SRCA_RD1 : srca = rd1;
            nf_cpu_pkg::SRCA_IMM : srca = ext_data;     // lui path
            nf_cpu_pkg::SRCA_PC  : srca = pc_v;         // auipc path
            default              : ;
        endcase
    end

    always_comb
    begin
        srcb = rd2;
        case (ctrl.srcb_sel)
            nf_cpu_pkg::SRCB_RD2 : srcb = rd2;
            nf_cpu_pkg::SRCB_IMM : srcb = ext_data;
            nf_cpu_pkg::SRCB_12  : srcb = ext_data << 12;
            default              : ;
        endcase
    end

    always_comb
    begin
        shift = rd2[4 : 0];
        case (ctrl.shift_sel)
            nf_cpu_pkg::SRCS_RD2   : shift = rd2[4 : 0];
            nf_cpu_pkg::SRCS_SHAMT : shift = shamt;
            nf_cpu_pkg::SRCS_12    : shift = 5'd12;
            default                : ;
        endcase
    end

    nf_alu alu_0
    (
        .srca       ( srca          ),  // source a
        .srcb       ( srcb          ),  // source b
        .shift      ( shift         ),  // shift amount
        .alu_code   ( ctrl.alu_code ),  // operation from decoder
        .result     ( result        )   // to writeback
    );

endmodule : nf_i_exu

// File: hdl/nf_pc_unit.sv
// program counter with sequential and beq / bne next-pc selection
// advances only on edges where an instruction was valid
`timescale 1ns/1ps

module nf_pc_unit
#(
    parameter logic [nf_cpu_pkg::XLEN-1 : 0] RESET_PC = '0     // pc after reset
)(
    input   logic                               clk,            // clock
    input   logic                               rst_n,          // sync reset, active low
    input   logic                               instr_vld,      // instruction strobe
    input   nf_cpu_pkg::branch_type_e           branch_type,    // branch condition
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    rd1,            // rs1 value
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    rd2,            // rs2 value
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    ext_data,       // b immediate
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    pc              // program counter
);

    logic                               taken;      // branch condition met
    logic   [nf_cpu_pkg::XLEN-1 : 0]    pc_next;

    always_comb
    begin
        case (branch_type)
            nf_cpu_pkg::BR_EQ : taken = (rd1 == rd2);
            nf_cpu_pkg::BR_NE : taken = (rd1 != rd2);
            default           : taken = 1'b0;
        endcase
    end

    assign pc_next = taken ? pc + ext_data : pc + 32'd4;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (instr_vld)
            pc <= pc_next;                          // holds when strobe low
    end

endmodule : nf_pc_unit

// File: hdl/nf_reg_file.sv
// 32 x 32 register file, two combinational reads, one clocked write
// x0 reads as zero and ignores writes
`timescale 1ns/1ps

module nf_reg_file
(
    input   logic                               clk,    // clock
    input   logic                               rst_n,  // sync reset, active low
    input   logic   [4 : 0]                     ra1,    // read address 1
    input   logic   [4 : 0]                     ra2,    // read address 2
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    rd1,    // read data 1
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    rd2,    // read data 2
    input   logic   [4 : 0]                     wa,     // write address
    input   logic   [nf_cpu_pkg::XLEN-1 : 0]    wd,     // write data
    input   logic                               we      // write enable
);

    logic   [nf_cpu_pkg::XLEN-1 : 0]    regs [1 : 31];  // x1..x31, no storage for x0

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;                      // all registers cleared
        end
        else if (we && (wa != 5'd0))
            regs[wa] <= wd;
    end

endmodule : nf_reg_file

// File: hdl/nf_sign_ex.sv
// immediate extraction and sign extension for i, u and b formats
// the u field is left unshifted, the exu applies the shift by 12
`timescale 1ns/1ps

module nf_sign_ex
(
    input   logic   [31 : 0]                    instr,      // instruction word
    input   nf_cpu_pkg::imm_src_e               imm_src,    // immediate format
    output  logic   [nf_cpu_pkg::XLEN-1 : 0]    ext_data    // extended immediate
);

    always_comb
    begin
        ext_data = '0;
        case (imm_src)
            nf_cpu_pkg::IMM_I :
                ext_data = { {20{instr[31]}}, instr[31 : 20] };
            nf_cpu_pkg::IMM_U :
                ext_data = { {12{instr[31]}}, instr[31 : 12] };      // raw 20 bit field
            nf_cpu_pkg::IMM_B :
                ext_data = { {19{instr[31]}}, instr[31], instr[7],
                             instr[30 : 25], instr[11 : 8], 1'b0 };  // bit 0 always zero
            default :
                ext_data = '0;
        endcase
    end

endmodule : nf_sign_ex

// File: run_sim.sh
#!/bin/sh
# build the core testbench with verilator, run it and grep the result line
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module nf_cpu_tb -f verilog.f -o nf_cpu_sim || exit 1
out=$(./obj_dir/nf_cpu_sim)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

// File: verilog.f
hdl/nf_cpu_pkg.sv
hdl/nf_exu_ctrl_if.sv
hdl/nf_control_unit.sv
hdl/nf_reg_file.sv
hdl/nf_sign_ex.sv
hdl/nf_alu.sv
hdl/nf_i_exu.sv
hdl/nf_pc_unit.sv
hdl/nf_cpu_core.sv
bench/nf_clk_gen.sv
bench/nf_cpu_props.sv
bench/nf_cpu_tb.sv
